// ==== project.f ====
design/pdp8_io_pkg.sv
design/io_mux.sv
design/tty_port.sv
design/mem_ext.sv
design/disk_regs.sv
design/io_subsystem.sv
tests/io_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the io_subsystem testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f project.f --top-module io_subsystem_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vio_subsystem_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== tests/io_subsystem_tb.sv ====
/* i/o subsystem testbench
   plays the cpu with directed iot sequences and checks the device answers */
`timescale 1ns/1ps

module io_subsystem_tb;

    localparam int clk_period      = 4;   // ns
    localparam int watchdog_cycles = 500; // tests need about 150 cycles
    localparam int line_kbd        = 0;
    localparam int line_tty        = 1;
    localparam int line_disk       = 2;

    logic                 clk;
    logic                 reset;
    pdp8_io_pkg::cpu_io_t cpu;
    logic [7:0]           kbd_char;
    logic                 kbd_strobe;
    logic                 tty_done;
    logic                 irq_in;
    logic                 disk_done;
    pdp8_io_pkg::word_t   in_bus;
    logic                 skip;
    logic [7:0]           tty_char;
    logic                 tty_send;
    logic [2:0]           ifield;
    logic [2:0]           dfield;
    pdp8_io_pkg::word_t   disk_addr;
    pdp8_io_pkg::word_t   disk_cmd;
    logic                 disk_go;
    pdp8_io_pkg::word_t   bus_display;

    pdp8_io_pkg::word_t seen_bus; // in_bus in the f3 cycle
    logic               seen_skip;
    integer             seed;
    integer             rnd;
    integer             errors;
    integer             tests_run;
    integer             tests_failed;

    io_subsystem io_subsystem_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic report_mismatch(input string what, input logic [11:0] got,
                                   input logic [11:0] expected);
        $display("Fail at %0t ns: %s is %o, expected %o", $time, what, got, expected);
        errors++;
    endtask

    task automatic close_test(input string name, input integer errors_before);
        tests_run++;
        if (errors != errors_before)
            tests_failed++;
        $display("test %0d %s: %0d mismatches", tests_run, name, errors - errors_before);
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    // f2 then f3, answer sampled mid f3, returns 1 ns into the next cycle
    task automatic run_iot(input pdp8_io_pkg::word_t instr,
                           input pdp8_io_pkg::word_t ac = '0);
        @(posedge clk);
        #1;
        cpu.state       = pdp8_io_pkg::state_f2;
        cpu.instruction = instr;
        cpu.ac          = ac;
        @(posedge clk);
        #1;
        cpu.state = pdp8_io_pkg::state_f3;
        #1;
        seen_bus  = in_bus;
        seen_skip = skip;
        @(posedge clk);
        #1;
        cpu = '0; // f0, null instruction
    endtask

    task automatic pulse_line(input int line);
        @(posedge clk);
        #1;
        case (line)
            line_kbd: kbd_strobe = 1'b1;
            line_tty: tty_done   = 1'b1;
            default:  disk_done  = 1'b1;
        endcase
        @(posedge clk);
        #1;
        kbd_strobe = 1'b0;
        tty_done   = 1'b0;
        disk_done  = 1'b0;
    endtask

    task automatic test_reset_state();
        integer             e0;
        pdp8_io_pkg::word_t ops [4];
        pdp8_io_pkg::word_t reads [3];
        e0    = errors;
        ops   = '{pdp8_io_pkg::iot_ksf, pdp8_io_pkg::iot_tsf, pdp8_io_pkg::iot_dskp,
                  pdp8_io_pkg::iot_skon};
        reads = '{pdp8_io_pkg::iot_krs, pdp8_io_pkg::iot_drst, pdp8_io_pkg::iot_rib};
        if (tty_send !== 1'b0) report_mismatch("tty_send after reset", {11'b0, tty_send}, 12'o0);
        if (disk_go !== 1'b0) report_mismatch("disk_go after reset", {11'b0, disk_go}, 12'o0);
        foreach (ops[i]) begin
            run_iot(ops[i]);
            if (seen_skip !== 1'b0) report_mismatch("skip after reset", {11'b0, seen_skip}, 12'o0);
        end
        if (bus_display !== 12'o0) report_mismatch("bus_display after reset", bus_display, 12'o0);
        foreach (reads[i]) begin // device registers read back empty
            run_iot(reads[i]);
            if (seen_bus !== 12'o0) report_mismatch("in_bus after reset", seen_bus, 12'o0);
        end
        close_test("reset state", e0);
    endtask

    task automatic test_keyboard();
        integer             e0;
        logic [7:0]         ch;
        pdp8_io_pkg::word_t expected;
        e0  = errors;
        rnd = $random(seed);
        ch  = rnd[7:0];
        run_iot(pdp8_io_pkg::iot_ksf);
        if (seen_skip !== 1'b0) report_mismatch("ksf before key", {11'b0, seen_skip}, 12'o0);
        kbd_char = ch;
        pulse_line(line_kbd);
        run_iot(pdp8_io_pkg::iot_ksf);
        if (seen_skip !== 1'b1) report_mismatch("ksf after key", {11'b0, seen_skip}, 12'o1);
        expected        = '0;
        expected[4:11]  = ch; // low 8 bits, upper four zero
        run_iot(pdp8_io_pkg::iot_krs);
        if (seen_bus !== expected) report_mismatch("krs in_bus", seen_bus, expected);
        run_iot(pdp8_io_pkg::iot_krb);
        if (seen_bus !== expected) report_mismatch("krb in_bus", seen_bus, expected);
        if (bus_display !== expected) report_mismatch("krb display", bus_display, expected);
        run_iot(pdp8_io_pkg::iot_ksf);
        if (seen_skip !== 1'b0) report_mismatch("ksf after krb", {11'b0, seen_skip}, 12'o0);
        close_test("keyboard path", e0);
    endtask

    task automatic test_printer();
        integer      e0;
        logic [11:0] ac_num;
        e0     = errors;
        rnd    = $random(seed);
        ac_num = rnd[11:0];
        run_iot(pdp8_io_pkg::iot_tls, ac_num);
        if (tty_send !== 1'b1) report_mismatch("tty_send after tls", {11'b0, tty_send}, 12'o1);
        if (tty_char !== ac_num[7:0])
            report_mismatch("tty_char", {4'b0, tty_char}, {4'b0, ac_num[7:0]});
        if (bus_display !== ac_num) report_mismatch("tls display", bus_display, ac_num);
        wait_cycle();
        if (tty_send !== 1'b0) report_mismatch("tty_send 2nd cycle", {11'b0, tty_send}, 12'o0);
        run_iot(pdp8_io_pkg::iot_tsf);
        if (seen_skip !== 1'b0) report_mismatch("tsf before done", {11'b0, seen_skip}, 12'o0);
        pulse_line(line_tty);
        run_iot(pdp8_io_pkg::iot_tsf);
        if (seen_skip !== 1'b1) report_mismatch("tsf after done", {11'b0, seen_skip}, 12'o1);
        run_iot(pdp8_io_pkg::iot_tcf);
        run_iot(pdp8_io_pkg::iot_tsf);
        if (seen_skip !== 1'b0) report_mismatch("tsf after tcf", {11'b0, seen_skip}, 12'o0);
        close_test("printer path", e0);
    endtask

    task automatic test_interrupts_fields();
        integer             e0;
        pdp8_io_pkg::word_t expected;
        e0 = errors;
        run_iot(pdp8_io_pkg::iot_ion);
        run_iot(pdp8_io_pkg::iot_skon);
        if (seen_skip !== 1'b1) report_mismatch("skon after ion", {11'b0, seen_skip}, 12'o1);
        run_iot(pdp8_io_pkg::iot_iof);
        run_iot(pdp8_io_pkg::iot_skon);
        if (seen_skip !== 1'b0) report_mismatch("skon after iof", {11'b0, seen_skip}, 12'o0);
        run_iot(pdp8_io_pkg::iot_srq);
        if (seen_skip !== 1'b0) report_mismatch("srq, irq low", {11'b0, seen_skip}, 12'o0);
        irq_in = 1'b1;
        run_iot(pdp8_io_pkg::iot_srq);
        if (seen_skip !== 1'b1) report_mismatch("srq, irq high", {11'b0, seen_skip}, 12'o1);
        run_iot(12'o6222); // cif 2 so rib has a saved field
        run_iot(12'o6231);
        run_iot(12'o6252);
        if (dfield !== 3'd3) report_mismatch("dfield", {9'b0, dfield}, 12'o3);
        if (ifield !== 3'd5) report_mismatch("ifield", {9'b0, ifield}, 12'o5);
        expected      = '0;
        expected[6:8] = 3'd3;
        run_iot(pdp8_io_pkg::iot_rdf);
        if (seen_bus !== expected) report_mismatch("rdf in_bus", seen_bus, expected);
        expected[6:8] = 3'd5;
        run_iot(pdp8_io_pkg::iot_rif);
        if (seen_bus !== expected) report_mismatch("rif in_bus", seen_bus, expected);
        expected[6:8] = 3'd2;
        run_iot(pdp8_io_pkg::iot_rib);
        if (seen_bus !== expected) report_mismatch("rib in_bus", seen_bus, expected);
        run_iot(pdp8_io_pkg::iot_ion);
        expected       = '0;
        expected[1]    = 1'b1; // irq_in
        expected[2]    = 1'b1; // interrupts on
        expected[6:8]  = 3'd5;
        expected[9:11] = 3'd3;
        run_iot(pdp8_io_pkg::iot_gtf);
        if (seen_bus !== expected) report_mismatch("gtf in_bus", seen_bus, expected);
        if (bus_display !== expected) report_mismatch("gtf display", bus_display, expected);
        irq_in = 1'b0;
        close_test("interrupts and fields", e0);
    endtask

    task automatic test_disk();
        integer             e0;
        logic [11:0]        addr;
        logic [11:0]        cmd;
        pdp8_io_pkg::word_t expected;
        e0   = errors;
        rnd  = $random(seed);
        addr = rnd[11:0];
        rnd  = $random(seed);
        cmd  = rnd[11:0];
        run_iot(pdp8_io_pkg::iot_dlag, addr);
        if (disk_go !== 1'b1) report_mismatch("disk_go after dlag", {11'b0, disk_go}, 12'o1);
        if (disk_addr !== addr) report_mismatch("disk_addr", disk_addr, addr);
        if (bus_display !== addr) report_mismatch("dlag display", bus_display, addr);
        wait_cycle();
        if (disk_go !== 1'b0) report_mismatch("disk_go 2nd cycle", {11'b0, disk_go}, 12'o0);
        run_iot(pdp8_io_pkg::iot_dldc, cmd);
        if (disk_cmd !== cmd) report_mismatch("disk_cmd", disk_cmd, cmd);
        run_iot(pdp8_io_pkg::iot_dldc, cmd); // now the loaded command shows
        if (seen_bus !== cmd) report_mismatch("dldc in_bus", seen_bus, cmd);
        run_iot(pdp8_io_pkg::iot_dskp);
        if (seen_skip !== 1'b0) report_mismatch("dskp before done", {11'b0, seen_skip}, 12'o0);
        pulse_line(line_disk);
        run_iot(pdp8_io_pkg::iot_dskp);
        if (seen_skip !== 1'b1) report_mismatch("dskp after done", {11'b0, seen_skip}, 12'o1);
        expected    = '0;
        expected[0] = 1'b1; // done in bit 0, the msb
        run_iot(pdp8_io_pkg::iot_drst);
        if (seen_bus !== expected) report_mismatch("drst in_bus", seen_bus, expected);
        if (bus_display !== expected) report_mismatch("drst display", bus_display, expected);
        run_iot(pdp8_io_pkg::iot_dclr);
        run_iot(pdp8_io_pkg::iot_dskp);
        if (seen_skip !== 1'b0) report_mismatch("dskp after dclr", {11'b0, seen_skip}, 12'o0);
        run_iot(pdp8_io_pkg::iot_drst);
        if (seen_bus !== 12'o0) report_mismatch("drst after dclr", seen_bus, 12'o0);
        close_test("disk registers", e0);
    endtask

    task automatic test_unmapped();
        integer             e0;
        pdp8_io_pkg::word_t ops [2];
        e0  = errors;
        ops = '{12'o1234, 12'o6100}; // tad, then an unused iot
        run_iot(pdp8_io_pkg::iot_rtf, 12'o5252);
        if (bus_display !== 12'o5252) report_mismatch("rtf display", bus_display, 12'o5252);
        foreach (ops[i]) begin
            run_iot(ops[i], 12'o7777);
            if (seen_bus !== 12'o0) report_mismatch("unmapped in_bus", seen_bus, 12'o0);
            if (seen_skip !== 1'b0) report_mismatch("unmapped skip", {11'b0, seen_skip}, 12'o0);
            if (bus_display !== 12'o5252)
                report_mismatch("unmapped display", bus_display, 12'o5252);
        end
        close_test("unmapped opcodes", e0);
    endtask

    initial begin
        seed         = 87063;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        cpu          = '0;
        kbd_char     = '0;
        kbd_strobe   = 1'b0;
        tty_done     = 1'b0;
        irq_in       = 1'b0;
        disk_done    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_keyboard();
        test_printer();
        test_interrupts_fields();
        test_disk();
        test_unmapped();

        $display("summary: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== design/io_subsystem.sv ====
/* pdp-8 i/o subsystem
   i/o mux with teletype, memory extension and disk register devices */
`timescale 1ns/1ps

module io_subsystem (
    input  logic                 clk,
    input  logic                 reset,
    input  pdp8_io_pkg::cpu_io_t cpu,
    input  logic [7:0]           kbd_char,
    input  logic                 kbd_strobe,
    input  logic                 tty_done,
    input  logic                 irq_in,
    input  logic                 disk_done,
    output pdp8_io_pkg::word_t   in_bus,
    output logic                 skip,
    output logic [7:0]           tty_char,
    output logic                 tty_send,
    output logic [2:0]           ifield,
    output logic [2:0]           dfield,
    output pdp8_io_pkg::word_t   disk_addr,
    output pdp8_io_pkg::word_t   disk_cmd,
    output logic                 disk_go,
    output pdp8_io_pkg::word_t   bus_display
);

    pdp8_io_pkg::dev_resp_t tty_resp;
    pdp8_io_pkg::dev_resp_t mem_resp;
    pdp8_io_pkg::dev_resp_t disk_resp;

    io_mux io_mux_i (
        .clk         (clk),
        .reset       (reset),
        .cpu         (cpu),
        .tty_resp    (tty_resp),
        .mem_resp    (mem_resp),
        .disk_resp   (disk_resp),
        .in_bus      (in_bus),
        .skip        (skip),
        .bus_display (bus_display)
    );

    tty_port tty_port_i (
        .clk        (clk),
        .reset      (reset),
        .cpu        (cpu),
        .kbd_char   (kbd_char),
        .kbd_strobe (kbd_strobe),
        .tty_done   (tty_done),
        .resp       (tty_resp),
        .tty_char   (tty_char),
        .tty_send   (tty_send)
    );

    mem_ext mem_ext_i (
        .clk    (clk),
        .reset  (reset),
        .cpu    (cpu),
        .irq_in (irq_in),
        .resp   (mem_resp),
        .ifield (ifield),
        .dfield (dfield)
    );

    disk_regs disk_regs_i (
        .clk       (clk),
        .reset     (reset),
        .cpu       (cpu),
        .disk_done (disk_done),
        .resp      (disk_resp),
        .disk_addr (disk_addr),
        .disk_cmd  (disk_cmd),
        .disk_go   (disk_go)
    );

endmodule

// ==== design/disk_regs.sv ====
/* disk controller registers
   done status, current address and command, with a start pulse */
`timescale 1ns/1ps

module disk_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  pdp8_io_pkg::cpu_io_t   cpu,
    input  logic                   disk_done,
    output pdp8_io_pkg::dev_resp_t resp,
    output pdp8_io_pkg::word_t     disk_addr,
    output pdp8_io_pkg::word_t     disk_cmd,
    output logic                   disk_go
);

    logic done;
    logic exec;

    assign exec = (cpu.state == pdp8_io_pkg::state_f3);

    always_ff @(posedge clk) begin
        if (reset) begin
            done      <= 1'b0;
            disk_addr <= '0;
            disk_cmd  <= '0;
            disk_go   <= 1'b0;
        end else begin
            disk_go <= exec && (cpu.instruction == pdp8_io_pkg::iot_dlag);
            if (exec) begin
                case (cpu.instruction)
                    pdp8_io_pkg::iot_dclr: done <= 1'b0;
                    pdp8_io_pkg::iot_dlag,
                    pdp8_io_pkg::iot_dlca: disk_addr <= cpu.ac;
                    pdp8_io_pkg::iot_dldc: disk_cmd <= cpu.ac;
                    default:               done <= done;
                endcase
            end
            if (disk_done)
                done <= 1'b1; // wins over dclr
        end
    end

    always_comb begin
        resp = '0;
        case (cpu.instruction)
            pdp8_io_pkg::iot_dskp: resp.skip = done;
            pdp8_io_pkg::iot_drst: resp.data = {done, 11'b0}; // status
            pdp8_io_pkg::iot_dldc: resp.data = disk_cmd;
            default:               resp = '0;
        endcase
    end

    // start is a one cycle pulse
    a_go_pulse: assert property (@(posedge clk) disable iff (reset)
        disk_go |=> !disk_go);

endmodule

// ==== design/mem_ext.sv ====
/* memory extension and interrupt unit
   interrupt enable, instruction and data fields, and their read-back */
`timescale 1ns/1ps

module mem_ext (
    input  logic                   clk,
    input  logic                   reset,
    input  pdp8_io_pkg::cpu_io_t   cpu,
    input  logic                   irq_in,
    output pdp8_io_pkg::dev_resp_t resp,
    output logic [2:0]             ifield,
    output logic [2:0]             dfield
);

    logic       int_enable;
    logic [2:0] save_field; // ifield before the last cif
    logic       exec;
    logic       is_cdf;
    logic       is_cif;

    assign exec = (cpu.state == pdp8_io_pkg::state_f3);

    // field number masked out of bits 6 to 8
    assign is_cdf = ((cpu.instruction & 12'o7707) == pdp8_io_pkg::iot_cdf_base);
    assign is_cif = ((cpu.instruction & 12'o7707) == pdp8_io_pkg::iot_cif_base);

    always_ff @(posedge clk) begin
        if (reset) begin
            int_enable <= 1'b0;
        end else if (exec) begin
            if (cpu.instruction == pdp8_io_pkg::iot_ion)
                int_enable <= 1'b1;
            else if (cpu.instruction == pdp8_io_pkg::iot_iof)
                int_enable <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ifield     <= '0;
            dfield     <= '0;
            save_field <= '0;
        end else if (exec) begin
            if (is_cdf)
                dfield <= cpu.instruction[6:8];
            if (is_cif) begin
                save_field <= ifield;
                ifield     <= cpu.instruction[6:8];
            end
        end
    end

    always_comb begin
        resp = '0;
        case (cpu.instruction)
            pdp8_io_pkg::iot_skon: resp.skip = int_enable;
            pdp8_io_pkg::iot_srq:  resp.skip = irq_in;
            pdp8_io_pkg::iot_gtf:
                resp.data = {1'b0, irq_in, int_enable, 3'b000, ifield, dfield};
            pdp8_io_pkg::iot_rdf:  resp.data = {6'b0, dfield, 3'b000};
            pdp8_io_pkg::iot_rif:  resp.data = {6'b0, ifield, 3'b000};
            pdp8_io_pkg::iot_rib:  resp.data = {6'b0, save_field, 3'b000};
            default:               resp = '0; // 625x too, no user mode
        endcase
    end

endmodule

// ==== design/tty_port.sv ====
/* teletype port
   keyboard buffer and flag, printer register and flag */
`timescale 1ns/1ps

module tty_port (
    input  logic                   clk,
    input  logic                   reset,
    input  pdp8_io_pkg::cpu_io_t   cpu,
    input  logic [7:0]             kbd_char,
    input  logic                   kbd_strobe,
    input  logic                   tty_done,
    output pdp8_io_pkg::dev_resp_t resp,
    output logic [7:0]             tty_char,
    output logic                   tty_send
);

    logic [7:0] kbd_buf;
    logic       kbd_flag;
    logic       tty_flag;
    logic       exec;

    assign exec = (cpu.state == pdp8_io_pkg::state_f3);

    // keyboard side
    always_ff @(posedge clk) begin
        if (reset) begin
            kbd_buf  <= '0;
            kbd_flag <= 1'b0;
        end else begin
            if (exec && (cpu.instruction == pdp8_io_pkg::iot_kcc ||
                         cpu.instruction == pdp8_io_pkg::iot_krb))
                kbd_flag <= 1'b0;
            if (kbd_strobe) begin // strobe beats a clear
                kbd_buf  <= kbd_char;
                kbd_flag <= 1'b1;
            end
        end
    end

    // printer side
    always_ff @(posedge clk) begin
        if (reset) begin
            tty_char <= '0;
            tty_flag <= 1'b0;
            tty_send <= 1'b0;
        end else begin
            tty_send <= exec && (cpu.instruction == pdp8_io_pkg::iot_tls);
            if (exec && (cpu.instruction == pdp8_io_pkg::iot_tcf ||
                         cpu.instruction == pdp8_io_pkg::iot_tls))
                tty_flag <= 1'b0;
            if (exec && cpu.instruction == pdp8_io_pkg::iot_tls)
                tty_char <= cpu.ac[4:11];
            if (tty_done)
                tty_flag <= 1'b1;
        end
    end

    always_comb begin
        resp = '0;
        case (cpu.instruction)
            pdp8_io_pkg::iot_ksf: resp.skip = kbd_flag;
            pdp8_io_pkg::iot_tsf: resp.skip = tty_flag;
            pdp8_io_pkg::iot_krs,
            pdp8_io_pkg::iot_krb: resp.data = {4'b0000, kbd_buf}; // zero extended
            default:              resp = '0;
        endcase
    end

    a_tty_send_pulse: assert property (@(posedge clk) disable iff (reset)
        tty_send |=> !tty_send);

endmodule

// ==== design/io_mux.sv ====
/* i/o multiplexer
   picks one device's data word and skip line for the current iot and
   keeps the front panel display register */
`timescale 1ns/1ps

module io_mux (
    input  logic                   clk,
    input  logic                   reset,
    input  pdp8_io_pkg::cpu_io_t   cpu,
    input  pdp8_io_pkg::dev_resp_t tty_resp,
    input  pdp8_io_pkg::dev_resp_t mem_resp,
    input  pdp8_io_pkg::dev_resp_t disk_resp,
    output pdp8_io_pkg::word_t     in_bus,
    output logic                   skip,
    output pdp8_io_pkg::word_t     bus_display
);

    pdp8_io_pkg::word_t lac;     // ac seen in f2
    pdp8_io_pkg::word_t lin_bus; // in_bus seen in f2

    // data source, uneven decode
    always_comb begin
        case (cpu.instruction)
            pdp8_io_pkg::iot_gtf,
            pdp8_io_pkg::iot_rdf,
            pdp8_io_pkg::iot_rif,
            pdp8_io_pkg::iot_rib:  in_bus = mem_resp.data;
            pdp8_io_pkg::iot_krs,
            pdp8_io_pkg::iot_krb:  in_bus = tty_resp.data;
            pdp8_io_pkg::iot_drst,
            pdp8_io_pkg::iot_dldc: in_bus = disk_resp.data;
            default:               in_bus = '0;
        endcase
    end

    // skip source
    always_comb begin
        casez (cpu.instruction)
            pdp8_io_pkg::iot_skon,
            pdp8_io_pkg::iot_srq:  skip = mem_resp.skip;
            12'o603?, 12'o604?:    skip = tty_resp.skip; // whole tty range
            pdp8_io_pkg::iot_dskp: skip = disk_resp.skip;
            default:               skip = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lac     <= '0;
            lin_bus <= '0;
        end else if (cpu.state == pdp8_io_pkg::state_f2) begin
            lac     <= cpu.ac;
            lin_bus <= in_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_display <= '0;
        end else if (cpu.state == pdp8_io_pkg::state_f3) begin
            case (cpu.instruction)
                pdp8_io_pkg::iot_gtf,
                pdp8_io_pkg::iot_krb,
                pdp8_io_pkg::iot_drst: bus_display <= lin_bus;
                pdp8_io_pkg::iot_rtf,
                12'o6044,              // tty print without flag clear
                pdp8_io_pkg::iot_tls,
                pdp8_io_pkg::iot_dclr,
                pdp8_io_pkg::iot_dlag,
                pdp8_io_pkg::iot_dlca: bus_display <= lac;
                default:               bus_display <= bus_display;
            endcase
        end
    end

    // no device may drive the bus outside the iot group
    a_resp_iot_only: assert property (@(posedge clk) disable iff (reset)
        (cpu.instruction[0:2] != 3'o6) |->
            (tty_resp == '0 && mem_resp == '0 && disk_resp == '0));

endmodule

// ==== design/pdp8_io_pkg.sv ====
/* pdp8 i/o package
   machine word type, cpu state codes, iot opcodes and the bundles
   passed between the cpu, the i/o mux and the devices */
package pdp8_io_pkg;

    typedef logic [0:11] word_t; // bit 0 is the msb, as on the pdp-8

    // cpu fetch states
    localparam logic [4:0] state_f0 = 5'd0;
    localparam logic [4:0] state_f1 = 5'd1;
    localparam logic [4:0] state_f2 = 5'd2; // operand phase
    localparam logic [4:0] state_f3 = 5'd3; // execute phase

    typedef struct packed {
        logic [4:0] state;
        word_t      instruction;
        word_t      ac;
    } cpu_io_t;

    typedef struct packed {
        word_t data;
        logic  skip;
    } dev_resp_t;

    // interrupt and flag
    localparam word_t iot_skon = 12'o6000;
    localparam word_t iot_ion  = 12'o6001;
    localparam word_t iot_iof  = 12'o6002;
    localparam word_t iot_srq  = 12'o6003;
    localparam word_t iot_gtf  = 12'o6004;
    localparam word_t iot_rtf  = 12'o6005;

    // keyboard
    localparam word_t iot_ksf = 12'o6031;
    localparam word_t iot_kcc = 12'o6032;
    localparam word_t iot_krs = 12'o6034;
    localparam word_t iot_krb = 12'o6036;

    // printer
    localparam word_t iot_tsf = 12'o6041;
    localparam word_t iot_tcf = 12'o6042;
    localparam word_t iot_tls = 12'o6046;

    // memory extension, field number sits in bits 6 to 8
    localparam word_t iot_cdf_base = 12'o6201;
    localparam word_t iot_cif_base = 12'o6202;
    localparam word_t iot_rdf      = 12'o6214;
    localparam word_t iot_rif      = 12'o6224;
    localparam word_t iot_rib      = 12'o6234;

    // disk
    localparam word_t iot_dskp = 12'o6741;
    localparam word_t iot_dclr = 12'o6743;
    localparam word_t iot_dlag = 12'o6744;
    localparam word_t iot_drst = 12'o6745;
    localparam word_t iot_dlca = 12'o6746;
    localparam word_t iot_dldc = 12'o6747;

endpackage
